// File: logic/spi_pkg.sv
/* SPI master shared definitions
   Default parameters, byte framing constants and clock generator states */
`default_nettype none

package spi_pkg;

	// Default SPI mode
	// Mode 0 gives cpol 0 and cpha 0
	localparam int spi_def_mode = 0;

	// Default clk cycles per serial half bit
	// Kept small so that simulation stays short
	localparam int spi_def_half_bit = 4;

	// Serial clock edges in one byte frame
	// Two edges per bit and eight bits
	localparam int spi_edges_per_byte = 16;

	// Index of the first bit on the wire, sent and received MSB first
	localparam int spi_byte_msb = 7;

	// Clock generator states
	typedef enum logic {
		gen_idle,
		gen_run
	} spi_gen_state_t;

endpackage

`default_nettype wire

// File: logic/spi_edge_if.sv
/* SPI edge interface
   Edge strobes and frame control from the clock generator to the shift engine */
`timescale 1ns/100ps
`default_nettype none

interface spi_edge_if;

	// One-cycle pulse on the cycle after an accepted din_valid
	logic start;
	// One-cycle strobe per leading serial clock edge
	logic lead;
	// One-cycle strobe per trailing serial clock edge
	logic trail;
	// High while no frame runs
	logic idle;

	// Clock generator side drives everything
	modport gen (
		output start,
		output lead,
		output trail,
		output idle
	);

	// Shift engine side only listens
	modport shift (
		input start,
		input lead,
		input trail,
		input idle
	);

endinterface

`default_nettype wire

// File: logic/spi_clock_gen.sv
/* SPI clock generator
   Divides clk into the serial clock and strobes the 16 edges of a byte frame */
`timescale 1ns/100ps
`default_nettype none

module spi_clock_gen #(
	parameter int SPI_MODE          = spi_pkg::spi_def_mode,
	parameter int CLKS_PER_HALF_BIT = spi_pkg::spi_def_half_bit
) (
	input  logic    clk,
	input  logic    rstn,
	input  logic    din_valid,
	output logic    tx_ready,
	output logic    sclk,
	spi_edge_if.gen edges
);
	import spi_pkg::*;

	// Half-bit counter runs over one full serial clock period
	localparam int half_w = $clog2(2 * CLKS_PER_HALF_BIT);
	// Edge counter must hold the full edge count
	localparam int edge_w = $clog2(spi_edges_per_byte + 1);

	// Count values where the internal clock toggles
	localparam logic [half_w-1:0] lead_at  = half_w'(CLKS_PER_HALF_BIT - 1);
	localparam logic [half_w-1:0] trail_at = half_w'(2 * CLKS_PER_HALF_BIT - 1);
	localparam logic [edge_w-1:0] frame_edges = edge_w'(spi_edges_per_byte);

	// Idle level of the serial clock, modes 2 and 3 idle high
	localparam logic cpol = (SPI_MODE == 2) || (SPI_MODE == 3);

	spi_gen_state_t      state;
	logic [edge_w-1:0]   edge_cnt;
	logic [half_w-1:0]   half_cnt;
	// Internal serial clock, sclk follows it one cycle later
	logic                sclk_int;
	logic                start_q;
	logic                lead_q;
	logic                trail_q;

	// Frame FSM with divider and edge counting
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state    <= gen_idle;
			tx_ready <= 1'b0;
			edge_cnt <= '0;
			half_cnt <= '0;
			sclk_int <= cpol;
			start_q  <= 1'b0;
			lead_q   <= 1'b0;
			trail_q  <= 1'b0;
		end
		else
		begin
			// Strobes last one cycle
			start_q <= 1'b0;
			lead_q  <= 1'b0;
			trail_q <= 1'b0;
			case (state)
				gen_idle:
				begin
					// Ready rises one cycle after reset or after a frame
					tx_ready <= 1'b1;
					// Only accept while ready is already showing
					if (din_valid && tx_ready)
					begin
						state    <= gen_run;
						tx_ready <= 1'b0;
						edge_cnt <= frame_edges;
						half_cnt <= '0;
						start_q  <= 1'b1;
					end
				end
				gen_run:
				begin
					if (edge_cnt == '0)
					begin
						// All edges done, give the last strobe a cycle to settle
						state    <= gen_idle;
						tx_ready <= 1'b1;
					end
					else if (half_cnt == trail_at)
					begin
						// End of a full period, trailing edge
						edge_cnt <= edge_cnt - 1'b1;
						half_cnt <= '0;
						sclk_int <= ~sclk_int;
						trail_q  <= 1'b1;
					end
					else if (half_cnt == lead_at)
					begin
						// Middle of the period, leading edge
						edge_cnt <= edge_cnt - 1'b1;
						half_cnt <= half_cnt + 1'b1;
						sclk_int <= ~sclk_int;
						lead_q   <= 1'b1;
					end
					else
					begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				default:
				begin
					state <= gen_idle;
				end
			endcase
		end
	end

	// Output clock lags the internal toggle by one cycle
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			sclk <= cpol;
		end
		else
		begin
			sclk <= sclk_int;
		end
	end

	// Strobes follow the internal toggle
	assign edges.start = start_q;
	assign edges.lead  = lead_q;
	assign edges.trail = trail_q;
	assign edges.idle  = (state == gen_idle);

endmodule

`default_nettype wire

// File: logic/spi_shift_engine.sv
/* SPI shift engine
   Latches the byte, shifts it out on mosi and assembles the reply from miso */
`timescale 1ns/100ps
`default_nettype none

module spi_shift_engine #(
	parameter int SPI_MODE = spi_pkg::spi_def_mode
) (
	input  logic       clk,
	input  logic       rstn,
	input  logic [7:0] din,
	input  logic       din_valid,
	input  logic       miso,
	output logic       mosi,
	output logic [7:0] dout,
	output logic       dout_valid,
	spi_edge_if.shift  edges
);
	import spi_pkg::*;

	localparam int idx_w = $clog2(spi_byte_msb + 1);
	localparam logic [idx_w-1:0] first_idx = idx_w'(spi_byte_msb);

	// Phase from mode, modes 1 and 3 use phase 1
	localparam logic cpha = (SPI_MODE == 1) || (SPI_MODE == 3);

	// Local copy of the byte, the caller may change din mid-frame
	logic [spi_byte_msb:0] tx_byte;
	logic [idx_w-1:0]      tx_idx;
	logic [idx_w-1:0]      rx_idx;
	// Set once bit 0 is on the wire
	logic                  tx_done;
	// Edge used for both launch and capture
	logic                  bit_edge;

	// Phase 0 works on trailing edges and phase 1 on leading edges
	// Capture on the same edge as launch leaves room for the slave's delay
	assign bit_edge = cpha ? edges.lead : edges.trail;

	// Byte latch, only taken when no frame runs
	always_ff @(posedge clk)
	begin
		if (din_valid && edges.idle)
		begin
			tx_byte <= din;
		end
	end

	// Transmit side
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			mosi    <= 1'b0;
			tx_idx  <= first_idx;
			tx_done <= 1'b0;
		end
		else if (edges.idle)
		begin
			// Rearm for the next frame, mosi keeps its last bit
			tx_idx  <= first_idx;
			tx_done <= 1'b0;
		end
		else if (edges.start && !cpha)
		begin
			// Phase 0 puts the MSB out before the first edge
			mosi   <= tx_byte[spi_byte_msb];
			tx_idx <= first_idx - 1'b1;
		end
		else if (bit_edge && !tx_done)
		begin
			mosi   <= tx_byte[tx_idx];
			tx_idx <= tx_idx - 1'b1;
			if (tx_idx == '0)
			begin
				tx_done <= 1'b1;
			end
		end
	end

	// Receive side
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			dout       <= '0;
			dout_valid <= 1'b0;
			rx_idx     <= first_idx;
		end
		else
		begin
			dout_valid <= 1'b0;
			if (edges.idle)
			begin
				rx_idx <= first_idx;
			end
			else if (bit_edge)
			begin
				dout[rx_idx] <= miso;
				rx_idx       <= rx_idx - 1'b1;
				// Last bit in, flag the byte
				if (rx_idx == '0)
				begin
					dout_valid <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/spi_master.sv
/* SPI master top level
   One byte out on mosi and one byte in from miso per frame, any mode */
`timescale 1ns/100ps
`default_nettype none

module spi_master #(
	parameter int SPI_MODE          = spi_pkg::spi_def_mode,
	parameter int CLKS_PER_HALF_BIT = spi_pkg::spi_def_half_bit
) (
	input  logic       clk,
	input  logic       rstn,
	input  logic [7:0] din,
	input  logic       din_valid,
	input  logic       miso,
	output logic       tx_ready,
	output logic [7:0] dout,
	output logic       dout_valid,
	output logic       sclk,
	output logic       mosi
);

	// Edge strobes and frame state between the two halves
	spi_edge_if edges ();

	// Divider, frame FSM and ready flag
	spi_clock_gen #(
		.SPI_MODE          (SPI_MODE),
		.CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
	) u_clock_gen (
		.clk       (clk),
		.rstn      (rstn),
		.din_valid (din_valid),
		.tx_ready  (tx_ready),
		.sclk      (sclk),
		.edges     (edges)
	);

	// Data path for both directions
	spi_shift_engine #(
		.SPI_MODE (SPI_MODE)
	) u_shift_engine (
		.clk        (clk),
		.rstn       (rstn),
		.din        (din),
		.din_valid  (din_valid),
		.miso       (miso),
		.mosi       (mosi),
		.dout       (dout),
		.dout_valid (dout_valid),
		.edges      (edges)
	);

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
/* Testbench clock and reset source
   20 ns clock, active low reset held over the first two rising edges */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rstn
);

	// Half of the 20 ns period
	localparam int half_period = 10;
	localparam int reset_cycles = 2;

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(half_period) clk = ~clk;
		end
	end

	// Reset low from time zero, released right on a rising edge
	initial
	begin
		rstn = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/tb_spi_master.sv
/* SPI master testbench
   Random byte exchange against a slave model, any mode and divider */
`timescale 1ns/100ps
`default_nettype none

module tb_spi_master #(
	parameter int SPI_MODE          = spi_pkg::spi_def_mode,
	parameter int CLKS_PER_HALF_BIT = spi_pkg::spi_def_half_bit
);
	import spi_pkg::*;

	localparam logic cpol = (SPI_MODE == 2) || (SPI_MODE == 3);
	localparam logic cpha = (SPI_MODE == 1) || (SPI_MODE == 3);
	localparam int num_frames = 32;
	// One frame plus some slack for ready and handoff
	localparam int frame_cycles = spi_edges_per_byte * CLKS_PER_HALF_BIT + 8;
	localparam int cycle_limit = 40 * frame_cycles;
	// Quiet time after the last frame to catch a stray extra frame
	localparam int quiet_cycles = 2 * frame_cycles;

	logic       clk;
	logic       rstn;
	logic [7:0] din;
	logic       din_valid;
	logic       miso;
	logic       tx_ready;
	logic [7:0] dout;
	logic       dout_valid;
	logic       sclk;
	logic       mosi;

	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// One expected byte per accepted frame
	logic [7:0] exp_mosi_q[$];
	logic [7:0] exp_dout_q[$];

	// Slave model state
	logic [7:0] slave_byte;
	logic [7:0] rec_byte;
	logic [7:0] got_byte;
	logic       got_strobe;
	logic       slave_seen;
	logic       lead_edge;
	int         rec_cnt;
	int         miso_idx;

	// Checker state
	logic sclk_last;
	logic ready_last;
	logic dv_last;
	logic in_frame;
	int   edge_total;
	int   dv_count = 0;
	int   got_count = 0;

	tb_clock u_clock (
		.clk  (clk),
		.rstn (rstn)
	);

	spi_master #(
		.SPI_MODE          (SPI_MODE),
		.CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
	) DUT (
		.clk        (clk),
		.rstn       (rstn),
		.din        (din),
		.din_valid  (din_valid),
		.miso       (miso),
		.tx_ready   (tx_ready),
		.dout       (dout),
		.dout_valid (dout_valid),
		.sclk       (sclk),
		.mosi       (mosi)
	);

	// Wire level model of one frame
	// Slave byte in the top half and master byte in the bottom half
	function automatic logic [15:0] model_exchange(input int mode, input logic [7:0] master_byte,
			input logic [7:0] slave_in);
		logic [7:0] at_slave;
		logic [7:0] at_master;
		logic       phase1;
		logic       is_lead;
		int         edge_no;
		int         bit_no;
		at_slave = '0;
		at_master = '0;
		phase1 = (mode == 1) || (mode == 3);
		for (edge_no = 0; edge_no < spi_edges_per_byte; edge_no++)
		begin
			// Two edges per bit and MSB first on both wires
			is_lead = (edge_no % 2) == 0;
			bit_no = spi_byte_msb - edge_no / 2;
			// Master takes miso on its capture edge and the slave takes mosi on the other
			if (is_lead == phase1)
			begin
				at_master[bit_no] = slave_in[bit_no];
			end
			else
			begin
				at_slave[bit_no] = master_byte[bit_no];
			end
		end
		return {at_slave, at_master};
	endfunction

	task automatic expect_level(input logic got, input logic want, input string what);
		checks++;
		assert (got === want)
		else
		begin
			errors++;
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic expect_byte(input logic [7:0] got, input logic [7:0] want,
			input string what);
		checks++;
		assert (got === want)
		else
		begin
			errors++;
			$display("FAIL %0t: %s is %02h, expected %02h", $time, what, got, want);
		end
	endtask

	// Slave model
	// Takes mosi where the master holds it steady and moves miso once the master took a bit
	initial
	begin
		miso = 1'b0;
		slave_seen = cpol;
		rec_byte = '0;
		rec_cnt = 0;
		miso_idx = spi_byte_msb;
		got_byte = '0;
		got_strobe = 1'b0;
		forever
		begin
			@(posedge clk);
			got_strobe <= 1'b0;
			if (din_valid && tx_ready)
			begin
				// MSB goes out before the first edge of a new frame
				rec_cnt = 0;
				rec_byte = '0;
				miso_idx = spi_byte_msb;
				miso <= slave_byte[spi_byte_msb];
			end
			else if (sclk !== slave_seen)
			begin
				// Leaving the idle level means a leading edge
				lead_edge = (slave_seen == cpol);
				slave_seen = sclk;
				if (lead_edge != cpha)
				begin
					rec_byte = {rec_byte[6:0], mosi};
					rec_cnt++;
					if (rec_cnt == 8)
					begin
						got_byte <= rec_byte;
						got_strobe <= 1'b1;
					end
				end
				else if (miso_idx > 0)
				begin
					miso_idx--;
					miso <= slave_byte[miso_idx];
				end
			end
		end
	end

	// Checker for data, pulse width, edge count and ready level
	always @(posedge clk)
	begin
		if (!rstn)
		begin
			sclk_last = cpol;
			ready_last = 1'b0;
			dv_last = 1'b0;
			in_frame = 1'b0;
			edge_total = 0;
		end
		else
		begin
			if (tx_ready)
			begin
				expect_level(sclk, cpol, "sclk between frames");
			end
			if (din_valid && tx_ready)
			begin
				in_frame = 1'b1;
				edge_total = 0;
			end
			if (sclk !== sclk_last)
			begin
				edge_total++;
				sclk_last = sclk;
				assert (in_frame)
				else
				begin
					errors++;
					$display("FAIL %0t: sclk toggled with no frame running", $time);
				end
				if (edge_total < spi_edges_per_byte)
				begin
					expect_level(tx_ready, 1'b0, "tx_ready inside a frame");
				end
			end
			if (dout_valid)
			begin
				dv_count++;
				assert (!dv_last && in_frame && exp_dout_q.size() > 0)
				else
				begin
					errors++;
					$display("FAIL %0t: dout_valid too wide or with no frame", $time);
				end
				if (!dv_last && exp_dout_q.size() > 0)
				begin
					expect_byte(dout, exp_dout_q.pop_front(), "dout");
				end
			end
			dv_last = dout_valid;
			if (got_strobe)
			begin
				got_count++;
				if (exp_mosi_q.size() > 0)
				begin
					expect_byte(got_byte, exp_mosi_q.pop_front(), "byte at slave");
				end
			end
			// Ready rising closes the frame
			if (tx_ready && !ready_last && in_frame)
			begin
				in_frame = 1'b0;
				checks++;
				assert (edge_total == spi_edges_per_byte)
				else
				begin
					errors++;
					$display("FAIL %0t: %0d sclk edges in frame, expected %0d", $time,
						edge_total, spi_edges_per_byte);
				end
			end
			ready_last = tx_ready;
		end
	end

	// Watchdog
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			errors++;
			$display("Timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("sim failed");
			$finish;
		end
	end

	// Stimulus
	initial
	begin
		logic [7:0]  m_byte;
		logic [7:0]  s_byte;
		logic [15:0] expv;
		int          frame;
		void'($urandom(32'h28515945));
		din = '0;
		din_valid = 1'b0;
		slave_byte = '0;
		// Reset values and then ready one cycle after release
		@(posedge clk);
		while (!rstn)
		begin
			@(posedge clk);
			expect_level(tx_ready, 1'b0, "tx_ready in reset");
			expect_level(sclk, cpol, "sclk after reset");
			expect_level(mosi, 1'b0, "mosi after reset");
			expect_level(dout_valid, 1'b0, "dout_valid after reset");
		end
		@(posedge clk);
		expect_level(tx_ready, 1'b1, "tx_ready after reset");
		for (frame = 0; frame < num_frames; frame++)
		begin
			m_byte = 8'($urandom);
			s_byte = 8'($urandom);
			expv = model_exchange(SPI_MODE, m_byte, s_byte);
			exp_mosi_q.push_back(expv[15:8]);
			exp_dout_q.push_back(expv[7:0]);
			while (!tx_ready)
			begin
				@(posedge clk);
			end
			din <= m_byte;
			din_valid <= 1'b1;
			slave_byte <= s_byte;
			@(posedge clk);
			din_valid <= 1'b0;
			// A strobe while busy in every fourth frame must be dropped
			// The last frame is one of them
			if (frame % 4 == 3)
			begin
				repeat (2 * CLKS_PER_HALF_BIT) @(posedge clk);
				expect_level(tx_ready, 1'b0, "tx_ready before busy strobe");
				din <= ~m_byte;
				din_valid <= 1'b1;
				@(posedge clk);
				din_valid <= 1'b0;
			end
			while (!dout_valid)
			begin
				@(posedge clk);
			end
			@(posedge clk);
			while (!tx_ready)
			begin
				@(posedge clk);
			end
		end
		// No extra frame may start from a dropped strobe
		repeat (quiet_cycles)
		begin
			@(posedge clk);
			expect_level(tx_ready, 1'b1, "tx_ready after last frame");
		end
		checks++;
		assert (dv_count == num_frames && got_count == num_frames)
		else
		begin
			errors++;
			$display("FAIL %0t: %0d dout_valid pulses and %0d slave bytes, expected %0d",
				$time, dv_count, got_count, num_frames);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("sim passed");
		end
		else
		begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: spi_master.f
logic/spi_pkg.sv
logic/spi_edge_if.sv
logic/spi_clock_gen.sv
logic/spi_shift_engine.sv
logic/spi_master.sv
dv/tb_clock.sv
dv/tb_spi_master.sv

// File: Makefile
# Verilator build, run and lint for the SPI master
# Mode and divider can be changed, e.g. make SPI_MODE=3 HALF_BIT=2

VERILATOR   ?= verilator
TOP         ?= tb_spi_master
RTL_TOP     ?= spi_master
FILELIST    ?= spi_master.f
OBJ_DIR     ?= obj_dir
SPI_MODE    ?= 0
HALF_BIT    ?= 4
PASS_MSG    ?= sim passed
RTL_SRCS    ?= logic/spi_pkg.sv logic/spi_edge_if.sv logic/spi_clock_gen.sv \
               logic/spi_shift_engine.sv logic/spi_master.sv
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS  ?= --lint-only -Wall
PARAMS      = -GSPI_MODE=$(SPI_MODE) -GCLKS_PER_HALF_BIT=$(HALF_BIT)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) $(PARAMS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
